/* common/sampler_pkg.sv */
/*
  Shared constants and types for the ML-DSA sampling back end.
  Input blocks are 64 bits and are consumed least significant bit first.
  Only uniform rejection (q = 8380417) and mask expansion are supported.
*/
package sampler_pkg;

  // field and polynomial
  localparam int COEFF_W       = 23;
  localparam int MLDSA_Q       = 8380417;
  localparam int COEFF_PER_CLK = 4;
  localparam int COEFF_CNT     = 256;
  localparam int OUT_CYCLES    = COEFF_CNT / COEFF_PER_CLK;
  localparam int OUT_CNT_W     = $clog2(OUT_CYCLES + 1);
  localparam int ADDR_W        = 14;

  // input blocks and buffer
  localparam int BLOCK_W     = 64;
  localparam int PISO_BUF_W  = 160;
  localparam int PISO_FILL_W = $clog2(PISO_BUF_W + 1);

  // uniform rejection, top bit of each 24-bit sample is dropped
  localparam int REJ_SAMPLE_W  = 24;
  localparam int REJ_OUT_RATE  = REJ_SAMPLE_W * COEFF_PER_CLK;
  localparam int REJ_BUF_DEPTH = 8;
  localparam int REJ_FILL_W    = $clog2(REJ_BUF_DEPTH + 1);

  // mask expansion
  localparam int EXP_SAMPLE_W = 20;
  localparam int EXP_OUT_RATE = EXP_SAMPLE_W * COEFF_PER_CLK;
  localparam int EXP_GAMMA1   = 1 << 19;

  typedef enum logic {
    MODE_REJ_UNIFORM = 1'b0,
    MODE_EXP_MASK    = 1'b1
  } sampler_mode_e;

  typedef enum logic [1:0] {
    ST_IDLE  = 2'b00,
    ST_RUN   = 2'b01,
    ST_FLUSH = 2'b10
  } sampler_state_e;

  typedef struct packed {
    logic               valid;
    logic [BLOCK_W-1:0] data;
  } block_t;

  // lane 0 in the low bits
  typedef logic [COEFF_PER_CLK-1:0][COEFF_W-1:0] coeff_vec_t;

  typedef struct packed {
    logic       dv;
    coeff_vec_t coeff;
  } ntt_out_t;

  typedef struct packed {
    logic              dv;
    logic [ADDR_W-1:0] addr;
    coeff_vec_t        coeff;
  } mem_wr_t;

endpackage

/* flist.f */
common/sampler_pkg.sv
piso/sampler_piso.sv
source/rej_sampler.sv
source/exp_mask.sv
source/sampler_ctrl.sv
source/sampler_top.sv
test/sampler_clk_gen.sv
test/sampler_props.sv
test/sampler_tb.sv

/* piso/sampler_piso.sv */
/*
  Multi-rate buffer, 64-bit blocks in, 96 (rejection) or 80 (mask) bits out.
  A block is taken only while the fill is at most 96 bits.
  Bits above the fill are kept zero so new blocks can be OR'ed in.
*/
`timescale 1ns/10ps

module sampler_piso (
  input  logic                                 clk,
  input  logic                                 rst_b,
  input  logic                                 clear_i,
  input  sampler_pkg::sampler_mode_e           mode_i,
  input  sampler_pkg::block_t                  block_i,
  input  logic                                 hold_i,
  output logic                                 hold_o,
  output logic                                 valid_o,
  output logic [sampler_pkg::REJ_OUT_RATE-1:0] data_o
);

  logic [sampler_pkg::PISO_BUF_W-1:0]  sbuf_q, sbuf_d;
  logic [sampler_pkg::PISO_BUF_W-1:0]  sbuf_shift;
  logic [sampler_pkg::PISO_BUF_W-1:0]  blk_ext;
  logic [sampler_pkg::PISO_FILL_W-1:0] fill_q, fill_d;
  logic [sampler_pkg::PISO_FILL_W-1:0] fill_shift;
  logic [sampler_pkg::PISO_FILL_W-1:0] out_rate;
  logic                                shift;
  logic                                accept;

  always_comb begin
    if (mode_i == sampler_pkg::MODE_REJ_UNIFORM) begin
      out_rate = sampler_pkg::PISO_FILL_W'(sampler_pkg::REJ_OUT_RATE);
    end else begin
      out_rate = sampler_pkg::PISO_FILL_W'(sampler_pkg::EXP_OUT_RATE);
    end
  end

  always_comb begin
    valid_o = (fill_q >= out_rate);
    hold_o  = (fill_q > sampler_pkg::PISO_FILL_W'(sampler_pkg::PISO_BUF_W -
                                                  sampler_pkg::BLOCK_W)) | hold_i;
    data_o  = sbuf_q[sampler_pkg::REJ_OUT_RATE-1:0];
    shift   = valid_o & ~hold_i;
    accept  = block_i.valid & ~hold_o;
  end

  // shift first, then append above what is left
  always_comb begin
    sbuf_shift = sbuf_q;
    fill_shift = fill_q;
    if (shift) begin
      sbuf_shift = sbuf_q >> out_rate;
      fill_shift = fill_q - out_rate;
    end

    blk_ext = {{(sampler_pkg::PISO_BUF_W - sampler_pkg::BLOCK_W){1'b0}}, block_i.data};
    blk_ext = blk_ext << fill_shift;

    sbuf_d = sbuf_shift;
    fill_d = fill_shift;
    if (accept) begin
      sbuf_d = sbuf_shift | blk_ext;
      fill_d = fill_shift + sampler_pkg::PISO_FILL_W'(sampler_pkg::BLOCK_W);
    end
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      sbuf_q <= '0;
      fill_q <= '0;
    end else if (clear_i) begin
      sbuf_q <= '0;
      fill_q <= '0;
    end else begin
      sbuf_q <= sbuf_d;
      fill_q <= fill_d;
    end
  end

endmodule

/* source/exp_mask.sv */
/*
  Mask expansion, four 20-bit samples to gamma1 - s mod q.
  One cycle latency, never holds the buffer.
*/
`timescale 1ns/10ps

module exp_mask (
  input  logic                                 clk,
  input  logic                                 rst_b,
  input  logic                                 clear_i,
  input  logic                                 valid_i,
  input  logic [sampler_pkg::EXP_OUT_RATE-1:0] data_i,
  output logic                                 dv_o,
  output sampler_pkg::coeff_vec_t              coeff_o
);

  logic [sampler_pkg::COEFF_PER_CLK-1:0][sampler_pkg::COEFF_W:0] diff;
  sampler_pkg::coeff_vec_t coeff_d;

  // top bit of diff is the sign, wrap by adding q
  always_comb begin
    for (int k = 0; k < sampler_pkg::COEFF_PER_CLK; k++) begin
      diff[k] = (sampler_pkg::COEFF_W+1)'(sampler_pkg::EXP_GAMMA1) -
                {{(sampler_pkg::COEFF_W + 1 - sampler_pkg::EXP_SAMPLE_W){1'b0}},
                 data_i[k*sampler_pkg::EXP_SAMPLE_W +: sampler_pkg::EXP_SAMPLE_W]};
      if (diff[k][sampler_pkg::COEFF_W]) begin
        coeff_d[k] = diff[k][sampler_pkg::COEFF_W-1:0] +
                     sampler_pkg::COEFF_W'(sampler_pkg::MLDSA_Q);
      end else begin
        coeff_d[k] = diff[k][sampler_pkg::COEFF_W-1:0];
      end
    end
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      dv_o <= 1'b0;
    end else if (clear_i) begin
      dv_o <= 1'b0;
    end else begin
      dv_o <= valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (valid_i) begin
      coeff_o <= coeff_d;
    end
  end

endmodule

/* source/rej_sampler.sv */
/*
  Uniform rejection sampler, four 24-bit candidates per input beat.
  Candidates below q are compacted in stream order; four are emitted
  per dv. Holds 0 to 7 coefficients, raises hold above 4.
*/
`timescale 1ns/10ps

module rej_sampler (
  input  logic                                 clk,
  input  logic                                 rst_b,
  input  logic                                 clear_i,
  input  logic                                 valid_i,
  input  logic [sampler_pkg::REJ_OUT_RATE-1:0] data_i,
  output logic                                 hold_o,
  output logic                                 dv_o,
  output sampler_pkg::coeff_vec_t              coeff_o
);

  logic [sampler_pkg::REJ_BUF_DEPTH-1:0][sampler_pkg::COEFF_W-1:0] ent_q, ent_d;

  sampler_pkg::coeff_vec_t                cand;
  logic [sampler_pkg::COEFF_PER_CLK-1:0]  acc;
  logic [sampler_pkg::REJ_FILL_W-1:0]     fill_q, fill_d;
  logic                                   pop;
  logic                                   take;
  logic                                   dv_q;
  sampler_pkg::coeff_vec_t                coeff_q;

  // compare lanes, bit 23 of each sample is dropped
  always_comb begin
    for (int k = 0; k < sampler_pkg::COEFF_PER_CLK; k++) begin
      cand[k] = data_i[k*sampler_pkg::REJ_SAMPLE_W +: sampler_pkg::COEFF_W];
      acc[k]  = (cand[k] < sampler_pkg::COEFF_W'(sampler_pkg::MLDSA_Q));
    end
  end

  always_comb begin
    hold_o = (fill_q > sampler_pkg::REJ_FILL_W'(sampler_pkg::COEFF_PER_CLK));
    pop    = (fill_q >= sampler_pkg::REJ_FILL_W'(sampler_pkg::COEFF_PER_CLK));
    take   = valid_i & ~hold_o;
  end

  // pop four from the head, then pack accepted lanes behind the rest
  always_comb begin
    ent_d  = ent_q;
    fill_d = fill_q;
    if (pop) begin
      for (int i = 0; i < sampler_pkg::COEFF_PER_CLK; i++) begin
        ent_d[i] = ent_q[i + sampler_pkg::COEFF_PER_CLK];
      end
      fill_d = fill_q - sampler_pkg::REJ_FILL_W'(sampler_pkg::COEFF_PER_CLK);
    end
    if (take) begin
      for (int k = 0; k < sampler_pkg::COEFF_PER_CLK; k++) begin
        if (acc[k]) begin
          ent_d[fill_d[sampler_pkg::REJ_FILL_W-2:0]] = cand[k];
          fill_d = fill_d + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      fill_q <= '0;
      dv_q   <= 1'b0;
    end else if (clear_i) begin
      fill_q <= '0;
      dv_q   <= 1'b0;
    end else begin
      fill_q <= fill_d;
      dv_q   <= pop;
    end
  end

  always_ff @(posedge clk) begin
    ent_q <= ent_d;
    if (pop) begin
      for (int i = 0; i < sampler_pkg::COEFF_PER_CLK; i++) begin
        coeff_q[i] <= ent_q[i];
      end
    end
  end

  always_comb begin
    dv_o    = dv_q;
    coeff_o = coeff_q;
  end

endmodule

/* source/sampler_ctrl.sv */
/*
  Run control. A run ends after 64 output cycles of the active port and
  is followed by one FLUSH cycle that drops leftover stream bits.
  Output dv is only passed while in RUN.
*/
`timescale 1ns/10ps

module sampler_ctrl (
  input  logic                           clk,
  input  logic                           rst_b,
  input  logic                           zeroize_i,
  input  sampler_pkg::sampler_mode_e     mode_i,
  input  logic                           start_i,
  input  logic [sampler_pkg::ADDR_W-1:0] dest_base_addr_i,
  input  logic                           piso_valid_i,
  input  logic                           rej_hold_i,
  input  logic                           rej_dv_i,
  input  sampler_pkg::coeff_vec_t        rej_coeff_i,
  input  logic                           exp_dv_i,
  input  sampler_pkg::coeff_vec_t        exp_coeff_i,
  output logic                           piso_hold_o,
  output logic                           rej_valid_o,
  output logic                           exp_valid_o,
  output logic                           clear_o,
  output logic                           busy_o,
  output sampler_pkg::ntt_out_t          ntt_o,
  output sampler_pkg::mem_wr_t           mem_o
);

  sampler_pkg::sampler_state_e state_q, state_d;

  logic [sampler_pkg::OUT_CNT_W-1:0] cnt_q, cnt_d;
  logic [sampler_pkg::ADDR_W-1:0]    addr_q, addr_d;
  logic                              rej_sel;
  logic                              vld_cycle;

  always_comb begin
    rej_sel   = (mode_i == sampler_pkg::MODE_REJ_UNIFORM);
    vld_cycle = (state_q == sampler_pkg::ST_RUN) & (rej_sel ? rej_dv_i : exp_dv_i);

    cnt_d  = cnt_q;
    addr_d = addr_q;
    if (start_i && (state_q == sampler_pkg::ST_IDLE)) begin
      cnt_d  = '0;
      addr_d = dest_base_addr_i;
    end else if (vld_cycle) begin
      cnt_d  = cnt_q + 1'b1;
      addr_d = addr_q + 1'b1;
    end
  end

  // leave RUN as soon as the last output cycle is counted
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      sampler_pkg::ST_IDLE: begin
        if (start_i) state_d = sampler_pkg::ST_RUN;
      end
      sampler_pkg::ST_RUN: begin
        if (cnt_d == sampler_pkg::OUT_CNT_W'(sampler_pkg::OUT_CYCLES)) begin
          state_d = sampler_pkg::ST_FLUSH;
        end
      end
      default: state_d = sampler_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      state_q <= sampler_pkg::ST_IDLE;
      cnt_q   <= '0;
      addr_q  <= '0;
    end else if (zeroize_i) begin
      state_q <= sampler_pkg::ST_IDLE;
      cnt_q   <= '0;
      addr_q  <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
      addr_q  <= addr_d;
    end
  end

  // steer buffer handshake to the selected sampler
  always_comb begin
    rej_valid_o = piso_valid_i & rej_sel;
    exp_valid_o = piso_valid_i & ~rej_sel;
    piso_hold_o = rej_sel & rej_hold_i;
  end

  always_comb begin
    clear_o = zeroize_i | (state_q == sampler_pkg::ST_FLUSH);
    busy_o  = start_i | (state_q != sampler_pkg::ST_IDLE);
  end

  always_comb begin
    ntt_o.dv    = vld_cycle & rej_sel;
    ntt_o.coeff = rej_coeff_i;
    mem_o.dv    = vld_cycle & ~rej_sel;
    mem_o.addr  = addr_q;
    mem_o.coeff = exp_coeff_i;
  end

endmodule

/* source/sampler_top.sv */
/*
  Sampling back end top. Blocks use a valid/hold handshake; the output
  ports have no ready. mode_i must stay stable while busy_o is high.
*/
`timescale 1ns/10ps

module sampler_top (
  input  logic                          clk,
  input  logic                          rst_b,
  input  logic                          zeroize_i,
  input  sampler_pkg::sampler_mode_e    mode_i,
  input  logic                          start_i,
  input  logic [sampler_pkg::ADDR_W-1:0] dest_base_addr_i,
  input  sampler_pkg::block_t           block_i,
  output logic                          hold_o,
  output logic                          busy_o,
  output sampler_pkg::ntt_out_t         ntt_o,
  output sampler_pkg::mem_wr_t          mem_o
);

  logic                                 clear;
  logic                                 piso_valid;
  logic                                 piso_hold;
  logic [sampler_pkg::REJ_OUT_RATE-1:0] piso_data;

  logic                   rej_valid;
  logic                   rej_hold;
  logic                   rej_dv;
  sampler_pkg::coeff_vec_t rej_coeff;

  logic                   exp_valid;
  logic                   exp_dv;
  sampler_pkg::coeff_vec_t exp_coeff;

  sampler_ctrl sampler_ctrl_i (
    .clk              (clk),
    .rst_b            (rst_b),
    .zeroize_i        (zeroize_i),
    .mode_i           (mode_i),
    .start_i          (start_i),
    .dest_base_addr_i (dest_base_addr_i),
    .piso_valid_i     (piso_valid),
    .rej_hold_i       (rej_hold),
    .rej_dv_i         (rej_dv),
    .rej_coeff_i      (rej_coeff),
    .exp_dv_i         (exp_dv),
    .exp_coeff_i      (exp_coeff),
    .piso_hold_o      (piso_hold),
    .rej_valid_o      (rej_valid),
    .exp_valid_o      (exp_valid),
    .clear_o          (clear),
    .busy_o           (busy_o),
    .ntt_o            (ntt_o),
    .mem_o            (mem_o)
  );

  sampler_piso sampler_piso_i (
    .clk     (clk),
    .rst_b   (rst_b),
    .clear_i (clear),
    .mode_i  (mode_i),
    .block_i (block_i),
    .hold_i  (piso_hold),
    .hold_o  (hold_o),
    .valid_o (piso_valid),
    .data_o  (piso_data)
  );

  rej_sampler rej_sampler_i (
    .clk     (clk),
    .rst_b   (rst_b),
    .clear_i (clear),
    .valid_i (rej_valid),
    .data_i  (piso_data),
    .hold_o  (rej_hold),
    .dv_o    (rej_dv),
    .coeff_o (rej_coeff)
  );

  // mask mode uses the low 80 bits only
  exp_mask exp_mask_i (
    .clk     (clk),
    .rst_b   (rst_b),
    .clear_i (clear),
    .valid_i (exp_valid),
    .data_i  (piso_data[sampler_pkg::EXP_OUT_RATE-1:0]),
    .dv_o    (exp_dv),
    .coeff_o (exp_coeff)
  );

endmodule

/* test/sampler_clk_gen.sv */
/*
  Clock and reset for the sampler testbench, 100 ns period.
  rst_b is held low for 8 cycles and released on a falling edge.
*/
`timescale 1ns/10ps

module sampler_clk_gen (
  output logic clk,
  output logic rst_b
);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    rst_b = 1'b0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_b = 1'b1;
  end

endmodule

/* test/sampler_props.sv */
/*
  Concurrent checks on the sampler_top output ports, bound into sampler_top.
  All checks are off while rst_b is low.
*/
`timescale 1ns/10ps

module sampler_props (
  input logic                  clk,
  input logic                  rst_b,
  input logic                  hold_i,
  input logic                  busy_i,
  input sampler_pkg::ntt_out_t ntt_i,
  input sampler_pkg::mem_wr_t  mem_i
);

  int unsigned fail_cnt = 0;
  logic        ntt_in_range;

  always_comb begin
    ntt_in_range = 1'b1;
    for (int k = 0; k < sampler_pkg::COEFF_PER_CLK; k++) begin
      if (ntt_i.coeff[k] >= sampler_pkg::COEFF_W'(sampler_pkg::MLDSA_Q)) ntt_in_range = 1'b0;
    end
  end

  dv_exclusive: assert property (@(posedge clk) disable iff (!rst_b)
    !(ntt_i.dv && mem_i.dv))
    else begin
      fail_cnt++;
      $error("ntt_o.dv and mem_o.dv are high in the same cycle");
    end

  dv_needs_busy: assert property (@(posedge clk) disable iff (!rst_b)
    (ntt_i.dv || mem_i.dv) |-> busy_i)
    else begin
      fail_cnt++;
      $error("output dv while busy_o is low");
    end

  // every kept candidate must already be reduced
  ntt_below_q: assert property (@(posedge clk) disable iff (!rst_b)
    ntt_i.dv |-> ntt_in_range)
    else begin
      fail_cnt++;
      $error("ntt_o coefficient at or above q");
    end

  hold_known: assert property (@(posedge clk) disable iff (!rst_b) !$isunknown(hold_i))
    else begin
      fail_cnt++;
      $error("hold_o is unknown");
    end

endmodule

/* test/sampler_tb.sv */
/*
  Testbench for sampler_top. Table rows run in order, each from a fresh
  stream, and blocks are only offered while a run is active.
*/
`timescale 1ns/10ps

module sampler_tb;

  localparam int NUM_ROWS  = 8;
  localparam int ROW_CYC   = 3000;
  localparam int QUIET_CYC = 16;

  typedef struct packed {
    sampler_pkg::sampler_mode_e     mode;
    logic [sampler_pkg::ADDR_W-1:0] base;
    logic                           heavy;
    logic [7:0]                     gap_pct;
    logic [15:0]                    zero_cyc;
  } row_t;

  logic                           clk;
  logic                           rst_b;
  logic                           zeroize;
  logic                           start;
  sampler_pkg::sampler_mode_e     mode;
  logic [sampler_pkg::ADDR_W-1:0] base_addr;
  sampler_pkg::block_t            block;
  logic                           hold;
  logic                           busy;
  sampler_pkg::ntt_out_t          ntt;
  sampler_pkg::mem_wr_t           mem;

  row_t                           rows [NUM_ROWS];
  bit                             stream_q [$];
  bit                             gen_q [$];
  int                             exp_q [$];
  sampler_pkg::sampler_mode_e     cur_mode;
  logic [sampler_pkg::ADDR_W-1:0] cur_base;
  int                             out_cnt;
  int                             err_cnt;
  int                             check_cnt;

  sampler_clk_gen sampler_clk_gen_i (.clk(clk), .rst_b(rst_b));

  sampler_top sampler_top_i (
    .clk              (clk),
    .rst_b            (rst_b),
    .zeroize_i        (zeroize),
    .mode_i           (mode),
    .start_i          (start),
    .dest_base_addr_i (base_addr),
    .block_i          (block),
    .hold_o           (hold),
    .busy_o           (busy),
    .ntt_o            (ntt),
    .mem_o            (mem)
  );

  bind sampler_top sampler_props sampler_props_i (
    .clk    (clk),
    .rst_b  (rst_b),
    .hold_i (hold_o),
    .busy_i (busy_o),
    .ntt_i  (ntt_o),
    .mem_i  (mem_o)
  );

  function automatic row_t make_row(input sampler_pkg::sampler_mode_e m, input int base,
                                    input bit heavy, input int gap, input int zcyc);
    row_t r;
    r.mode     = m;
    r.base     = base[sampler_pkg::ADDR_W-1:0];
    r.heavy    = heavy;
    r.gap_pct  = gap[7:0];
    r.zero_cyc = zcyc[15:0];
    return r;
  endfunction

  task automatic expect_eq(input string name, input logic [31:0] exp_val,
                           input logic [31:0] act_val);
    check_cnt++;
    if (act_val !== exp_val) begin
      err_cnt++;
      $display("error: %0d ns, %s, expected %0h, actual %0h", $time, name, exp_val, act_val);
    end
  endtask

  task automatic report_fault(input string msg);
    err_cnt++;
    $display("at %0d ns: %s", $time, msg);
  endtask

  // reject-heavy blocks are built from whole 24-bit candidates, half of them >= q
  function automatic logic [63:0] next_block(input bit heavy);
    logic [63:0] blk;
    int unsigned cand;
    if (!heavy) begin
      blk = {$urandom, $urandom};
      return blk;
    end
    while (gen_q.size() < sampler_pkg::BLOCK_W) begin
      if ($urandom_range(1) == 1) begin
        cand = sampler_pkg::MLDSA_Q + $urandom_range((1 << 23) - sampler_pkg::MLDSA_Q - 1);
      end else begin
        cand = $urandom_range(sampler_pkg::MLDSA_Q - 1);
      end
      cand[23] = $urandom_range(1);
      for (int b = 0; b < sampler_pkg::REJ_SAMPLE_W; b++) gen_q.push_back(cand[b]);
    end
    for (int b = 0; b < sampler_pkg::BLOCK_W; b++) blk[b] = gen_q.pop_front();
    return blk;
  endfunction

  // reference model, turns accepted stream bits into expected coefficients
  task automatic record_block(input logic [63:0] data, input sampler_pkg::sampler_mode_e m);
    int unsigned val;
    int          d;
    for (int b = 0; b < sampler_pkg::BLOCK_W; b++) stream_q.push_back(data[b]);
    if (m == sampler_pkg::MODE_REJ_UNIFORM) begin
      while (stream_q.size() >= sampler_pkg::REJ_SAMPLE_W) begin
        val = 0;
        for (int b = 0; b < sampler_pkg::REJ_SAMPLE_W; b++) val[b] = stream_q.pop_front();
        val[23] = 1'b0;
        if (val < sampler_pkg::MLDSA_Q) exp_q.push_back(val);
      end
    end else begin
      while (stream_q.size() >= sampler_pkg::EXP_SAMPLE_W) begin
        val = 0;
        for (int b = 0; b < sampler_pkg::EXP_SAMPLE_W; b++) val[b] = stream_q.pop_front();
        d = sampler_pkg::EXP_GAMMA1 - int'(val);
        if (d < 0) d = d + sampler_pkg::MLDSA_Q;
        exp_q.push_back(d);
      end
    end
  endtask

  task automatic check_outputs();
    logic                           act_dv;
    logic [sampler_pkg::ADDR_W-1:0] exp_addr;
    sampler_pkg::coeff_vec_t        act_coeff;
    string                          port;
    if (cur_mode == sampler_pkg::MODE_REJ_UNIFORM) begin
      act_dv    = ntt.dv;
      act_coeff = ntt.coeff;
      port      = "ntt_o";
      expect_eq("mem_o.dv", 0, mem.dv);
    end else begin
      act_dv    = mem.dv;
      act_coeff = mem.coeff;
      port      = "mem_o";
      expect_eq("ntt_o.dv", 0, ntt.dv);
    end
    if (!busy) expect_eq("hold_o", 0, hold);
    if (act_dv) begin
      if (!busy) report_fault({port, ".dv is high while busy_o is low"});
      if (out_cnt >= sampler_pkg::OUT_CYCLES) begin
        report_fault({port, ".dv is high after the 64th output cycle"});
      end else if (exp_q.size() < sampler_pkg::COEFF_PER_CLK) begin
        report_fault({port, " gave an output cycle the stream does not cover"});
        out_cnt++;
      end else begin
        if (cur_mode == sampler_pkg::MODE_EXP_MASK) begin
          exp_addr = cur_base + sampler_pkg::ADDR_W'(out_cnt);
          expect_eq("mem_o.addr", exp_addr, mem.addr);
        end
        for (int k = 0; k < sampler_pkg::COEFF_PER_CLK; k++) begin
          expect_eq($sformatf("%s.coeff[%0d]", port, k), exp_q.pop_front(), act_coeff[k]);
        end
        out_cnt++;
      end
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      start         <= 1'b0;
      zeroize       <= 1'b0;
      block.valid   <= 1'b0;
      @(negedge clk);
      expect_eq("busy_o", 0, busy);
      expect_eq("hold_o", 0, hold);
      expect_eq("ntt_o.dv", 0, ntt.dv);
      expect_eq("mem_o.dv", 0, mem.dv);
    end
  endtask

  task automatic run_row(input int idx);
    row_t  r;
    int    cyc;
    int    tail;
    int    err_before;
    bit    take;
    bit    zeroized;
    bit    done;
    string label;
    r          = rows[idx];
    err_before = err_cnt;
    stream_q.delete();
    gen_q.delete();
    exp_q.delete();
    cur_mode   = r.mode;
    cur_base   = r.base;
    out_cnt    = 0;
    cyc        = 0;
    tail       = 0;
    take       = 1'b0;
    zeroized   = 1'b0;
    done       = 1'b0;
    @(posedge clk);
    mode      <= r.mode;
    base_addr <= r.base;
    start     <= 1'b1;
    @(negedge clk);
    expect_eq("busy_o", 1, busy);
    while (!done) begin
      @(posedge clk);
      start   <= 1'b0;
      zeroize <= 1'b0;
      cyc++;
      if (r.zero_cyc != 0 && cyc == r.zero_cyc) begin
        zeroize     <= 1'b1;
        block.valid <= 1'b0;
        zeroized = 1'b1;
      end else if (zeroized || out_cnt >= sampler_pkg::OUT_CYCLES) begin
        block.valid <= 1'b0;
      end else if (block.valid && !take) begin
        // held block stays on the bus
      end else if ($urandom_range(99) < r.gap_pct) begin
        block.valid <= 1'b0;
      end else begin
        block.valid <= 1'b1;
        block.data  <= next_block(r.heavy);
      end
      @(negedge clk);
      take = block.valid && !hold;
      if (take) record_block(block.data, r.mode);
      check_outputs();
      if (zeroized) begin
        if (cyc > r.zero_cyc) begin
          expect_eq("busy_o", 0, busy);
          done = 1'b1;
        end
      end else if (out_cnt >= sampler_pkg::OUT_CYCLES) begin
        if (!busy) begin
          done = 1'b1;
        end else if (tail == 2) begin
          report_fault("busy_o still high two cycles after the last output cycle");
          done = 1'b1;
        end
        tail++;
      end else if (!busy) begin
        report_fault($sformatf("busy_o fell after only %0d output cycles", out_cnt));
        done = 1'b1;
      end
    end
    if (zeroized) begin
      idle_cycles(QUIET_CYC);
    end else begin
      expect_eq("output cycles", sampler_pkg::OUT_CYCLES, out_cnt);
      idle_cycles(4);
    end
    if (r.mode == sampler_pkg::MODE_REJ_UNIFORM) label = "rejection";
    else label = "mask";
    if (r.heavy) label = {label, ", reject-heavy"};
    if (zeroized) label = {label, ", zeroize"};
    $display("row %0d (%s, gap %0d%%): %0d output cycles, %0d mismatches",
             idx, label, r.gap_pct, out_cnt, err_cnt - err_before);
  endtask

  initial begin
    int prop_fails;
    void'($urandom(76400));
    err_cnt   = 0;
    check_cnt = 0;
    zeroize   = 1'b0;
    start     = 1'b0;
    mode      = sampler_pkg::MODE_REJ_UNIFORM;
    base_addr = '0;
    block     = '0;
    // mode, base, heavy, gap %, zeroize cycle
    rows[0] = make_row(sampler_pkg::MODE_REJ_UNIFORM, 'h0000, 0, 0, 0);
    rows[1] = make_row(sampler_pkg::MODE_REJ_UNIFORM, 'h0000, 1, 30, 0);
    rows[2] = make_row(sampler_pkg::MODE_EXP_MASK, 'h0100, 0, 0, 0);
    rows[3] = make_row(sampler_pkg::MODE_REJ_UNIFORM, 'h0000, 1, 10, 40);
    rows[4] = make_row(sampler_pkg::MODE_REJ_UNIFORM, 'h0000, 0, 20, 0);
    rows[5] = make_row(sampler_pkg::MODE_EXP_MASK, 'h2a40, 1, 25, 0);
    rows[6] = make_row(sampler_pkg::MODE_EXP_MASK, 'h0555, 0, 0, 30);
    rows[7] = make_row(sampler_pkg::MODE_EXP_MASK, 'h1000, 0, 15, 0);
    @(posedge rst_b);
    @(negedge clk);
    expect_eq("busy_o", 0, busy);
    expect_eq("hold_o", 0, hold);
    expect_eq("ntt_o.dv", 0, ntt.dv);
    expect_eq("mem_o.dv", 0, mem.dv);
    for (int i = 0; i < NUM_ROWS; i++) run_row(i);
    prop_fails = sampler_top_i.sampler_props_i.fail_cnt;
    $display("%0d rows, %0d checks, %0d mismatches, %0d assertion failures",
             NUM_ROWS, check_cnt, err_cnt, prop_fails);
    if (err_cnt == 0 && prop_fails == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    repeat (NUM_ROWS * ROW_CYC) @(posedge clk);
    $display("watchdog: run did not finish within %0d cycles", NUM_ROWS * ROW_CYC);
    $display("Checks failed");
    $finish;
  end

endmodule
